// ==== source/regBankPkg.sv ====
package regBankPkg;

	// Geometry of the bank
	localparam int AddrWidth = 5;
	localparam int DataWidth = 32;
	localparam int NumBytes = 4;
	localparam int NumWords = 32;

	typedef logic [AddrWidth-1:0] addrT; // Word address
	typedef logic [DataWidth-1:0] dataT;
	typedef logic [NumBytes-1:0] byteEnT; // One bit per byte lane
	typedef logic [NumWords-1:0] wordMaskT;

	// All stored words side by side, word 0 in the low bits
	typedef logic [NumWords*DataWidth-1:0] memImageT;

	// Request payload, 42 bits
	typedef struct packed {
		logic write;
		addrT addr;
		dataT wdata;
		byteEnT be;
	} regReqT;

	// Response payload, 33 bits
	typedef struct packed {
		logic write;
		dataT rdata; // Zero for writes
	} regRespT;

endpackage

// ==== source/clockGate.sv ====
`timescale 1ns/1ns

module clockGate (
	input logic clk,
	input logic en,
	output logic gatedClk
);

	logic enLatched;

	// Enable may only change while clk is low
	always_latch begin
		if (!clk) begin
			enLatched <= en;
		end
	end

	assign gatedClk = clk & enLatched; // Glitch free since enLatched is stable while clk is high

endmodule

// ==== source/registerFile1r1w.sv ====
`timescale 1ns/1ns

module registerFile1r1w (
	input logic clk,
	input logic readEnable,
	input regBankPkg::addrT readAddr,
	output regBankPkg::dataT readData,
	input logic writeEnable,
	input regBankPkg::addrT writeAddr,
	input regBankPkg::dataT writeData,
	input regBankPkg::byteEnT writeBe,
	output regBankPkg::memImageT memContent
);
	import regBankPkg::*;

	addrT readAddrReg;
	dataT writeDataReg; // Byte lanes sampled on clk
	logic clkWrite; // Gated clock that only toggles on write cycles
	logic [NumWords*NumBytes-1:0] byteStrobe;
	logic [NumWords*NumBytes-1:0] byteClk;
	logic [7:0] memBytes [NumWords][NumBytes];

	clockGate u_clockGateGlobal (
		.clk(clk),
		.en(writeEnable),
		.gatedClk(clkWrite)
	);

	// Read address register
	always_ff @(posedge clk) begin
		if (readEnable) begin
			readAddrReg <= readAddr;
		end
	end

	always_comb begin
		for (int b = 0; b < NumBytes; b++) begin
			readData[b*8 +: 8] = memBytes[readAddrReg][b];
		end
	end

	// One-hot decode of word address and byte mask
	always_comb begin
		for (int w = 0; w < NumWords; w++) begin
			for (int b = 0; b < NumBytes; b++) begin
				byteStrobe[w*NumBytes + b] = writeEnable && writeBe[b] &&
					(writeAddr == addrT'(w));
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int b = 0; b < NumBytes; b++) begin
			if (writeEnable && writeBe[b]) begin
				writeDataReg[b*8 +: 8] <= writeData[b*8 +: 8];
			end
		end
	end

	for (genvar w = 0; w < NumWords; w++) begin : gWord
		for (genvar b = 0; b < NumBytes; b++) begin : gByte
			clockGate u_clockGateByte (
				.clk(clkWrite),
				.en(byteStrobe[w*NumBytes + b]),
				.gatedClk(byteClk[w*NumBytes + b])
			);

			// Transparent during the high phase after the accepting edge
			always_latch begin
				if (byteClk[w*NumBytes + b]) begin
					memBytes[w][b] <= writeDataReg[b*8 +: 8];
				end
			end

			assign memContent[w*DataWidth + b*8 +: 8] = memBytes[w][b];
		end
	end

endmodule

// ==== source/regBankCtrl.sv ====
`timescale 1ns/1ns

module regBankCtrl (
	input logic clk,
	input logic reset,
	input logic reqValid,
	output logic reqReady,
	input regBankPkg::regReqT reqData,
	output logic respValid,
	input logic respReady,
	output regBankPkg::regRespT respData,
	output logic readEnable,
	output regBankPkg::addrT readAddr,
	input regBankPkg::dataT readData,
	output logic writeEnable,
	output regBankPkg::addrT writeAddr,
	output regBankPkg::dataT writeData,
	output regBankPkg::byteEnT writeBe
);
	import regBankPkg::*;

	// Tracks the request whose read data is on the port this cycle
	typedef struct packed {
		logic valid;
		logic write;
	} stageT;

	stageT stage;
	logic reqAccept;
	logic respFree; // Response register can take a new entry
	logic stageAdvance;
	logic respValidReg;
	regRespT respReg;
	dataT nextRdata;

	assign respFree = !respValidReg || respReady;
	assign stageAdvance = stage.valid && respFree;

	// Both slots full and nothing leaving
	assign reqReady = !stage.valid || respFree;
	assign reqAccept = reqValid && reqReady;

	// Port strobes are high only in the accepting cycle
	always_comb begin
		readEnable = reqAccept && !reqData.write;
		readAddr = reqData.addr;
		writeEnable = reqAccept && reqData.write;
		writeAddr = reqData.addr;
		writeData = reqData.wdata;
		writeBe = reqData.be;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			stage <= '0;
		end else if (reqAccept) begin
			stage.valid <= 1'b1;
			stage.write <= reqData.write;
		end else if (stageAdvance) begin
			stage.valid <= 1'b0;
		end
	end

	// Writes answer with zero data
	always_comb begin
		if (stage.write) begin
			nextRdata = '0;
		end else begin
			nextRdata = readData;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			respValidReg <= 1'b0;
		end else if (respFree) begin
			respValidReg <= stage.valid;
		end
	end

	// Payload holds while stalled
	always_ff @(posedge clk) begin
		if (stageAdvance) begin
			respReg.write <= stage.write;
			respReg.rdata <= nextRdata;
		end
	end

	assign respValid = respValidReg;
	assign respData = respReg;

endmodule

// ==== source/wordActiveFlags.sv ====
`timescale 1ns/1ns

module wordActiveFlags (
	input logic clk,
	input logic reset,
	input regBankPkg::memImageT memContent,
	output regBankPkg::wordMaskT activeFlags
);
	import regBankPkg::*;

	wordMaskT nonZero;
	wordMaskT flagsReg;

	// OR-reduce each stored word
	always_comb begin
		for (int w = 0; w < NumWords; w++) begin
			nonZero[w] = |memContent[w*DataWidth +: DataWidth];
		end
	end

	// Flags held clear during reset
	always_ff @(posedge clk) begin
		if (reset) begin
			flagsReg <= '0;
		end else begin
			flagsReg <= nonZero;
		end
	end

	assign activeFlags = flagsReg;

endmodule

// ==== source/regBankTop.sv ====
`timescale 1ns/1ns

module regBankTop (
	input logic clk,
	input logic reset,
	input logic reqValid,
	output logic reqReady,
	input regBankPkg::regReqT reqData,
	output logic respValid,
	input logic respReady,
	output regBankPkg::regRespT respData,
	output regBankPkg::wordMaskT activeFlags
);
	import regBankPkg::*;

	logic readEnable;
	addrT readAddr;
	dataT readData;
	logic writeEnable;
	addrT writeAddr;
	dataT writeData;
	byteEnT writeBe;
	memImageT memContent; // Only watched by the flag block

	regBankCtrl u_regBankCtrl (
		.clk(clk),
		.reset(reset),
		.reqValid(reqValid),
		.reqReady(reqReady),
		.reqData(reqData),
		.respValid(respValid),
		.respReady(respReady),
		.respData(respData),
		.readEnable(readEnable),
		.readAddr(readAddr),
		.readData(readData),
		.writeEnable(writeEnable),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.writeBe(writeBe)
	);

	registerFile1r1w u_registerFile1r1w (
		.clk(clk),
		.readEnable(readEnable),
		.readAddr(readAddr),
		.readData(readData),
		.writeEnable(writeEnable),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.writeBe(writeBe),
		.memContent(memContent)
	);

	wordActiveFlags u_wordActiveFlags (
		.clk(clk),
		.reset(reset),
		.memContent(memContent),
		.activeFlags(activeFlags)
	);

endmodule

// ==== tb/regBank_assert.sv ====
`timescale 1ns/1ns

module regBankAssert (
	input logic clk,
	input logic reset,
	input logic reqValid,
	input logic reqReady,
	input logic respValid,
	input logic respReady,
	input regBankPkg::regRespT respData
);

	int failCount = 0;
	logic [1:0] inFlight; // Accepted requests not yet answered

	always_ff @(posedge clk) begin
		if (reset) begin
			inFlight <= '0;
		end else begin
			inFlight <= inFlight + 2'(reqValid && reqReady) - 2'(respValid && respReady);
		end
	end

	// A stalled response keeps its valid and its payload
	holdResp: assert property (@(posedge clk) disable iff (reset)
		respValid && !respReady |=> respValid && $stable(respData))
		else begin
			failCount++;
			$error("response changed while respReady was low");
		end

	// Two requests held and the response stalled
	noAcceptWhenFull: assert property (@(posedge clk) disable iff (reset)
		inFlight == 2'd2 && !respReady |-> !(reqValid && reqReady))
		else begin
			failCount++;
			$error("request accepted while both slots were full");
		end

	idleAfterReset: assert property (@(posedge clk)
		reset |=> !respValid)
		else begin
			failCount++;
			$error("respValid high right after a reset edge");
		end

endmodule

// ==== tb/regBankTb.sv ====
`timescale 1ns/1ns

module regBankTb;
	import regBankPkg::*;

	typedef struct packed {
		regRespT resp;
		int acceptEdge; // Edge that took the request
	} expectT;

	logic clk = 1'b0;
	logic reset;
	logic reqValid;
	logic reqReady;
	regReqT reqData;
	logic respValid;
	logic respReady;
	regRespT respData;
	wordMaskT activeFlags;

	regReqT vecReq [64];
	int vecTest [64];
	int vecStall [64]; // Longest respReady low stretch for this response
	int numVec = 0;
	dataT model [NumWords];
	expectT expQ [$];
	int edgeCount = 0;
	int errorCount = 0;
	int checkCount = 0;
	int testCount = 0;
	int seed = 47314;
	bit timedOut = 1'b0;

	regBankTop u_regBankTop (
		.clk(clk),
		.reset(reset),
		.reqValid(reqValid),
		.reqReady(reqReady),
		.reqData(reqData),
		.respValid(respValid),
		.respReady(respReady),
		.respData(respData),
		.activeFlags(activeFlags)
	);

	bind regBankCtrl regBankAssert u_regBankAssert (
		.clk(clk),
		.reset(reset),
		.reqValid(reqValid),
		.reqReady(reqReady),
		.respValid(respValid),
		.respReady(respReady),
		.respData(respData)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		edgeCount <= edgeCount + 1;
	end

	task automatic checkValue(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("** Error at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
		end
	endtask

	task automatic loadVectors();
		int fd;
		int code;
		int t;
		int w;
		int st;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] be;
		string line;
		fd = $fopen("tb/regBankVectors.txt", "r");
		if (fd == 0) begin
			$display("Could not open tb/regBankVectors.txt");
			errorCount++;
			return;
		end
		while (!$feof(fd) && numVec < 64) begin
			line = "";
			code = $fgets(line, fd);
			if (code > 0 && line[0] != "#" &&
				$sscanf(line, "%d %d %h %h %h %d", t, w, a, d, be, st) == 6) begin
				vecTest[numVec] = t;
				vecReq[numVec].write = (w != 0);
				vecReq[numVec].addr = addrT'(a);
				vecReq[numVec].wdata = d;
				vecReq[numVec].be = byteEnT'(be);
				vecStall[numVec] = st;
				numVec++;
			end
		end
		$fclose(fd);
		if (numVec == 0) begin
			$display("No vectors found in tb/regBankVectors.txt");
			errorCount++;
		end
	endtask

	// Byte merge under the write mask
	function automatic void mergeWrite(input regReqT req);
		for (int b = 0; b < NumBytes; b++) begin
			if (req.be[b]) begin
				model[req.addr][b*8 +: 8] = req.wdata[b*8 +: 8];
			end
		end
	endfunction

	function automatic wordMaskT nonZeroMask();
		wordMaskT mask;
		for (int w = 0; w < NumWords; w++) begin
			mask[w] = (model[w] != '0);
		end
		return mask;
	endfunction

	task automatic runTest(input int first, input int last);
		int next;
		int got;
		int idle;
		int stallLeft;
		int stallFor;
		int errorsBefore;
		bit noStall;
		logic expReady;
		logic reqFire;
		logic respFire;
		expectT head;
		expectT entry;
		next = first;
		got = first;
		idle = 0;
		stallLeft = 0;
		stallFor = -1;
		errorsBefore = errorCount;
		noStall = 1'b1;
		for (int i = first; i <= last; i++) begin
			if (vecStall[i] != 0) begin
				noStall = 1'b0;
			end
		end
		while (got <= last) begin
			@(negedge clk);
			if (respValid && stallFor != got) begin // Fresh response on the bus
				stallFor = got;
				if (vecStall[got] > 0) begin
					stallLeft = 1 + int'($unsigned($random(seed)) % vecStall[got]);
				end
			end
			respReady = (stallLeft == 0);
			if (stallLeft > 0) begin
				stallLeft--;
			end
			if (next <= last) begin
				reqValid = 1'b1;
				reqData = vecReq[next];
			end else begin
				reqValid = 1'b0;
				reqData = '0;
			end
			#1;
			expReady = !((next - got) == 2 && !respReady); // Both slots held
			checkValue("reqReady", 64'(reqReady), 64'(expReady));
			reqFire = reqValid && reqReady;
			respFire = respValid && respReady;
			if (respFire) begin
				if (expQ.size() == 0) begin
					$display("Response at %0t ns arrived with no request pending", $time);
					errorCount++;
				end else begin
					head = expQ.pop_front();
					checkValue("respData.write", 64'(respData.write), 64'(head.resp.write));
					checkValue("respData.rdata", 64'(respData.rdata), 64'(head.resp.rdata));
					if (noStall) begin
						checkValue("respValid edge", 64'(edgeCount + 1), 64'(head.acceptEdge + 2));
					end
				end
				got++;
			end
			if (reqFire) begin
				entry.acceptEdge = edgeCount + 1;
				entry.resp.write = vecReq[next].write;
				entry.resp.rdata = vecReq[next].write ? '0 : model[vecReq[next].addr];
				if (vecReq[next].write) begin
					mergeWrite(vecReq[next]);
				end
				expQ.push_back(entry);
				next++;
			end
			if (reqFire || respFire) begin
				idle = 0;
			end else begin
				idle++;
			end
			if (idle >= 200) begin
				$display("Timeout in test %0d: no handshake for 200 cycles", vecTest[first]);
				errorCount++;
				timedOut = 1'b1;
				break;
			end
		end
		if (!timedOut) begin
			repeat (3) @(negedge clk); // Two edges past the last response
			checkValue("respValid", 64'(respValid), 64'd0);
			checkValue("activeFlags", 64'(activeFlags), 64'(nonZeroMask()));
		end
		testCount++;
		$display("Test %0d: %0d requests, %0d errors", vecTest[first], last - first + 1,
			errorCount - errorsBefore);
	endtask

	initial begin
		int first;
		int last;
		reset = 1'b1;
		reqValid = 1'b0;
		reqData = '0;
		respReady = 1'b1;
		for (int w = 0; w < NumWords; w++) begin
			model[w] = '0;
		end
		loadVectors();
		repeat (10) @(posedge clk);
		@(negedge clk);
		checkValue("respValid", 64'(respValid), 64'd0);
		checkValue("reqReady", 64'(reqReady), 64'd1);
		checkValue("activeFlags", 64'(activeFlags), 64'd0);
		reset = 1'b0;
		first = 0;
		while (first < numVec && !timedOut) begin
			last = first;
			while (last + 1 < numVec && vecTest[last + 1] == vecTest[first]) begin
				last++;
			end
			runTest(first, last);
			first = last + 1;
		end
		errorCount += u_regBankTop.u_regBankCtrl.u_regBankAssert.failCount;
		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== tb/regBankVectors.txt ====
# test write addr(hex) data(hex) be(hex) stall
# stall is the longest respReady low stretch for that response, 0 for none
0 1 00 00000000 f 0
0 1 01 00000000 f 0
0 1 02 00000000 f 0
0 1 03 00000000 f 0
0 1 04 00000000 f 0
0 1 05 00000000 f 0
0 1 06 00000000 f 0
0 1 07 00000000 f 0
0 1 08 00000000 f 0
0 1 09 00000000 f 0
0 1 0a 00000000 f 0
0 1 0b 00000000 f 0
0 1 0c 00000000 f 0
0 1 0d 00000000 f 0
0 1 0e 00000000 f 0
0 1 0f 00000000 f 0
0 1 10 00000000 f 0
0 1 11 00000000 f 0
0 1 12 00000000 f 0
0 1 13 00000000 f 0
0 1 14 00000000 f 0
0 1 15 00000000 f 0
0 1 16 00000000 f 0
0 1 17 00000000 f 0
0 1 18 00000000 f 0
0 1 19 00000000 f 0
0 1 1a 00000000 f 0
0 1 1b 00000000 f 0
0 1 1c 00000000 f 0
0 1 1d 00000000 f 0
0 1 1e 00000000 f 0
0 1 1f 00000000 f 0
1 1 03 a5a5c3c3 f 0
1 0 03 00000000 0 0
1 1 1f 12345678 f 0
1 0 1f 00000000 0 0
2 1 05 11223344 f 0
2 1 05 aabbccdd 5 0
2 0 05 00000000 0 0
2 1 05 000000ee 2 0
2 0 05 00000000 0 0
3 1 0a cafef00d f 0
3 0 0a 00000000 0 0
3 1 0b 0badbeef c 0
3 0 0b 00000000 0 0
3 0 03 00000000 0 0
4 1 10 deadbeef f 3
4 0 10 00000000 0 4
4 0 05 00000000 0 2
4 1 11 00000001 1 3
4 0 11 00000000 0 5
5 1 03 00000000 f 0
5 1 1f ff000000 7 0
5 1 0a 00000000 f 0
5 0 0a 00000000 0 0
6 0 10 00000000 0 0
6 1 12 00c0ffee f 0
6 0 12 00000000 0 0
6 0 1f 00000000 0 0

// ==== filelist.f ====
source/regBankPkg.sv
source/clockGate.sv
source/registerFile1r1w.sv
source/regBankCtrl.sv
source/wordActiveFlags.sv
source/regBankTop.sv
tb/regBank_assert.sv
tb/regBankTb.sv

// ==== Makefile ====
SOURCES := $(wildcard source/*.sv) $(wildcard tb/*.sv)

.PHONY: run clean

run: obj_dir/VregBankTb tb/regBankVectors.txt
	./obj_dir/VregBankTb > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@grep -q "Simulation completed successfully" sim.log

obj_dir/VregBankTb: $(SOURCES) filelist.f
	verilator --binary --timing --assert --top-module regBankTb -f filelist.f

clean:
	rm -rf obj_dir sim.log
